// ==== bench/fcmp_assert.sv ====
// Bound into fcmpApb; done is the compare unit's internal result-valid flag.
`default_nettype none

`include "fcmp_defs.svh"

module fcmp_assert (
  input logic       clk,
  input logic       rst,
  input logic       psel,
  input logic       penable,
  input logic       pwrite,
  input logic [7:0] paddr,
  input logic       pready,
  input logic       done
);

  logic ctrlWrite;

  assign ctrlWrite = psel & penable & pwrite & (paddr == `FCMP_ADDR_CTRL);

  readyHigh: assert property (@(posedge clk) pready)
    else $error("pready went low");

  // The access cycle of a CTRL write is the start, so done follows one cycle later.
  doneAfterStart: assert property (@(posedge clk) disable iff (rst) ctrlWrite |=> done)
    else $error("done did not rise in the cycle after a CTRL write");

  doneLowInReset: assert property (@(posedge clk) rst |=> !done)
    else $error("done was high during reset");

endmodule

bind fcmpApb fcmp_assert apbChecks (
  .clk     (clk),
  .rst     (rst),
  .psel    (psel),
  .penable (penable),
  .pwrite  (pwrite),
  .paddr   (paddr),
  .pready  (pready),
  .done    (done)
);

`default_nettype wire

// ==== bench/fcmp_patterns.hex ====
// First word: vector count. Then one vector per line, all hex:
// operand A, operand B, CTRL word, expected STATUS word.
1e
3FF0000000000000 4000000000000000 01 00010004
4000000000000000 3FF0000000000000 01 00010320
3FF0000000000000 3FF0000000000000 01 00010322
BFF0000000000000 3FF0000000000000 01 00010004
3FF0000000000000 BFF0000000000000 01 00010320
C000000000000000 BFF0000000000000 01 00010004
BFF0000000000000 C000000000000000 01 00010320
0000000000000000 8000000000000000 01 00010322
7FF0000000000000 FFF0000000000000 01 00010320
FFF0000000000000 FFF0000000000000 01 00010322
7FF8000000000000 3FF0000000000000 01 00010011
3FF0000000000000 7FF8000000000000 31 00010311
7FF8000000000000 7FF8000000000000 09 00010011
3FF0000000000000 4000000000000000 09 00010000
3FF0000000000000 3FF0000000000000 29 00010020
400000003F800000 3F80000040000000 10 00010304
0000000040000000 000000003F800000 00 00010320
000000003F800000 000000003F800000 20 00010322
000000003F800000 00000000BF800000 30 00010320
400000003F800000 3F80000040000000 02 00010204
400000003F800000 3F80000040000000 12 00010104
3F8000003F800000 400000003F800000 22 00010122
3F8000003F800000 400000003F800000 32 00010222
7FC000003F800000 3F8000003F800000 02 00010122
0000000000000000 0000000000000000 04 00010300
0000000000800000 0000000000000000 04 00010325
8000000000000000 0000000000008000 04 0001002E
0000000080000000 0000000000000000 04 00010326
0000000000000000 8000000000000000 04 0001033E
0000000000000000 0000000000000080 04 00010030

// ==== bench/fcmp_tb.sv ====
// Vectors come from bench/fcmp_patterns.hex, so the simulation must run from the project root.
`default_nettype none

`include "fcmp_defs.svh"

module fcmp_tb;

  import fcmp_pkg::*;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [63:0] vecMem [0:255];
  int          vecCount;
  int          failures;
  integer      seed;

  tbClock clkGen (
    .clk (clk)
  );

  fcmpApb UUT (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  function automatic logic [63:0] vecWord(input int n);
    return vecMem[n[7:0]];
  endfunction

  task automatic failRun(input string why);
    failures++;
    $display("Simulation FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic checkStatus(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      failRun("status word mismatch");
    end
  endtask

  task automatic checkOperand(input string name, input fpWord_u got, input fpWord_u exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      failRun("operand readback mismatch");
    end
  endtask

  task automatic checkErr(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      failRun("pslverr mismatch");
    end
  endtask

  // Setup phase, access phase, then sample at the edge that closes the transfer.
  task automatic apbAccess(input logic write, input logic [7:0] addr, input logic [31:0] data,
                           output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    while (!pready) begin
      @(posedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] ignored;
    apbAccess(1'b1, addr, data, ignored, err);
  endtask

  task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apbAccess(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic readOperand(input logic [7:0] loAddr, output fpWord_u word);
    logic [31:0] lo;
    logic [31:0] hi;
    logic        err;
    apbRead(loAddr, lo, err);
    apbRead(loAddr + 8'h04, hi, err);
    word = {hi, lo};
  endtask

  task automatic writeOperand(input logic [7:0] loAddr, input fpWord_u word);
    logic err;
    apbWrite(loAddr, word.lanes[3:0], err);
    apbWrite(loAddr + 8'h04, word.lanes[7:4], err);
  endtask

  initial begin
    fpWord_u     opA;
    fpWord_u     opB;
    fpWord_u     expA;
    fpWord_u     expB;
    logic [31:0] rdata;
    logic [31:0] ctrlWord;
    logic [31:0] expStatus;
    logic        err;
    $readmemh("bench/fcmp_patterns.hex", vecMem);
    vecCount = int'(vecWord(0));
    failures = 0;
    seed     = 32'he1dc;
    rst      <= 1'b1;
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    paddr    <= 8'h0;
    pwdata   <= 32'h0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    apbRead(`FCMP_ADDR_STATUS, rdata, err);
    checkStatus("status after reset", rdata, 32'h0);

    expA = {$random(seed), $random(seed)};
    expB = {$random(seed), $random(seed)};
    writeOperand(`FCMP_ADDR_ALO, expA);
    writeOperand(`FCMP_ADDR_BLO, expB);
    readOperand(`FCMP_ADDR_ALO, opA);
    checkOperand("operand A readback", opA, expA);
    readOperand(`FCMP_ADDR_BLO, opB);
    checkOperand("operand B readback", opB, expB);

    apbWrite(`FCMP_ADDR_STATUS, 32'h0, err);
    checkErr("pslverr on STATUS write", err, 1'b1);
    apbRead(8'h18, rdata, err);
    checkErr("pslverr on unmapped read", err, 1'b1);
    apbWrite(8'h40, 32'h1234, err);
    checkErr("pslverr on unmapped write", err, 1'b1);
    apbRead(`FCMP_ADDR_ALO, rdata, err);
    checkErr("pslverr on mapped read", err, 1'b0);

    for (int v = 0; v < vecCount; v++) begin
      opA       = vecWord(4 * v + 1);
      opB       = vecWord(4 * v + 2);
      ctrlWord  = 32'(vecWord(4 * v + 3));
      expStatus = 32'(vecWord(4 * v + 4));
      writeOperand(`FCMP_ADDR_ALO, opA);
      writeOperand(`FCMP_ADDR_BLO, opB);
      apbWrite(`FCMP_ADDR_CTRL, ctrlWord, err); // Starts the compare.
      checkErr($sformatf("pslverr on CTRL write of vector %0d", v), err, 1'b0);
      apbRead(`FCMP_ADDR_STATUS, rdata, err);
      checkStatus($sformatf("status of vector %0d", v), rdata, expStatus);
    end

    if (failures == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Each vector takes six transfers of three cycles; the extra 100 covers reset and setup.
  initial begin
    #1;
    repeat (vecCount * 20 + 100) @(posedge clk);
    $display("Timeout: the test sequence did not finish within %0d cycles.", vecCount * 20 + 100);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== bench/tbClock.sv ====
// Free-running clock with a period of 40 time units; it starts low, so the first rising edge is at 20.
`default_nettype none

module tbClock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #20;
    clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== include/fcmp_defs.svh ====
// Register map, control bits and flag layout of the compare unit; all addresses are byte offsets.
`ifndef FCMP_DEFS_SVH
`define FCMP_DEFS_SVH

`define FCMP_ADDR_ALO    8'h00
`define FCMP_ADDR_AHI    8'h04
`define FCMP_ADDR_BLO    8'h08
`define FCMP_ADDR_BHI    8'h0C
`define FCMP_ADDR_CTRL   8'h10
`define FCMP_ADDR_STATUS 8'h14

`define FCMP_CTRL_W      6
`define FCMP_CTRL_DBL    0
`define FCMP_CTRL_PAIRED 1
`define FCMP_CTRL_SRCH   2
`define FCMP_CTRL_AFM    3
`define FCMP_CTRL_CMOD   5:4

`define FCMP_F_GE        5
`define FCMP_F_UNORD_HI  4
`define FCMP_F_S         2
`define FCMP_F_Z         1
`define FCMP_F_UNORD_LO  0

`define FCMP_COND_GE     2'd0
`define FCMP_COND_LT     2'd1
`define FCMP_COND_EQ     2'd2
`define FCMP_COND_NE     2'd3

`define FCMP_STAT_FLAGS  5:0
`define FCMP_STAT_COND   9:8
`define FCMP_STAT_DONE   16

`endif

// ==== rtl/fcmpApb.sv ====
// APB slave with no wait states; write operands before CTRL, since a CTRL write starts the compare.
`default_nettype none

`include "fcmp_defs.svh"

module fcmpApb (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  import fcmp_pkg::*;

  fpWord_u                  opA;
  fpWord_u                  opB;
  logic [`FCMP_CTRL_W-1:0]  ctrl;
  logic [`FCMP_CTRL_W-1:0]  ctrlNow;
  logic                     access;
  logic                     wrEn;
  logic                     mapped;
  logic                     start;
  logic [5:0]               flags;
  logic [1:0]               cond;
  logic                     done;
  logic [31:0]              status;

  assign access = psel & penable;
  assign wrEn   = access & pwrite;
  assign start  = wrEn & (paddr == `FCMP_ADDR_CTRL);
  assign pready = 1'b1;

  always_comb begin
    case (paddr)
      `FCMP_ADDR_ALO, `FCMP_ADDR_AHI,
      `FCMP_ADDR_BLO, `FCMP_ADDR_BHI,
      `FCMP_ADDR_CTRL, `FCMP_ADDR_STATUS: mapped = 1'b1;
      default:                            mapped = 1'b0;
    endcase
  end

  // STATUS is read only.
  assign pslverr = access & (~mapped | (pwrite & (paddr == `FCMP_ADDR_STATUS)));

  always_ff @(posedge clk) begin
    if (rst) begin
      opA  <= '0;
      opB  <= '0;
      ctrl <= '0;
    end else if (wrEn) begin
      case (paddr)
        `FCMP_ADDR_ALO:  opA.lanes[3:0] <= pwdata;
        `FCMP_ADDR_AHI:  opA.lanes[7:4] <= pwdata;
        `FCMP_ADDR_BLO:  opB.lanes[3:0] <= pwdata;
        `FCMP_ADDR_BHI:  opB.lanes[7:4] <= pwdata;
        `FCMP_ADDR_CTRL: ctrl <= pwdata[`FCMP_CTRL_W-1:0];
        default: ;
      endcase
    end
  end

  // The compare runs in the write cycle itself, before ctrl has loaded.
  assign ctrlNow = start ? pwdata[`FCMP_CTRL_W-1:0] : ctrl;

  fpCompare cmpUnit (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .operandA (opA),
    .operandB (opB),
    .isDbl    (ctrlNow[`FCMP_CTRL_DBL]),
    .paired   (ctrlNow[`FCMP_CTRL_PAIRED]),
    .search   (ctrlNow[`FCMP_CTRL_SRCH]),
    .afm      (ctrlNow[`FCMP_CTRL_AFM]),
    .cmod     (ctrlNow[`FCMP_CTRL_CMOD]),
    .flags    (flags),
    .cond     (cond),
    .done     (done)
  );

  always_comb begin
    status                   = 32'b0;
    status[`FCMP_STAT_FLAGS] = flags;
    status[`FCMP_STAT_COND]  = cond;
    status[`FCMP_STAT_DONE]  = done;
  end

  always_comb begin
    prdata = 32'b0;
    if (psel & ~pwrite) begin
      case (paddr)
        `FCMP_ADDR_ALO:    prdata = opA.lanes[3:0];
        `FCMP_ADDR_AHI:    prdata = opA.lanes[7:4];
        `FCMP_ADDR_BLO:    prdata = opB.lanes[3:0];
        `FCMP_ADDR_BHI:    prdata = opB.lanes[7:4];
        `FCMP_ADDR_CTRL:   prdata = {{(32 - `FCMP_CTRL_W){1'b0}}, ctrl};
        `FCMP_ADDR_STATUS: prdata = status;
        default:           prdata = 32'b0; // Unmapped reads return zero.
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fcmp_pkg.sv ====
// Operand words are 64 bits wide; byte lane 0 is the least significant byte.
`default_nettype none

package fcmp_pkg;

  // IEEE double layout of a full operand word.
  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] frac;
  } dblField_t;

  // One operand word, read either as a double or as eight byte lanes.
  // The lane view also carries the two packed singles (lanes 7:4 and 3:0).
  typedef union packed {
    dblField_t       dbl;
    logic [7:0][7:0] lanes;
  } fpWord_u;

endpackage

`default_nettype wire

// ==== rtl/firstBitFind.sv ====
// Fixed 16-bit width; index is zero when no bit is set.
`default_nettype none

module firstBitFind (
  input  logic [15:0] bits,
  output logic [3:0]  index,
  output logic        found
);

  always_comb begin
    index = 4'd0;
    // Scanning downwards lets the lowest set bit win.
    for (int i = 15; i >= 0; i--) begin
      if (bits[i]) begin
        index = 4'(i);
      end
    end
  end

  assign found = |bits;

endmodule

`default_nettype wire

// ==== rtl/fpCmpLane.sv ====
// Results are only meaningful for the format chosen by half and isDbl; lt and eq are low when unordered.
`default_nettype none

module fpCmpLane (
  input  fcmp_pkg::fpWord_u a,
  input  fcmp_pkg::fpWord_u b,
  input  logic              half,
  input  logic              isDbl,
  output logic              lt,
  output logic              eq,
  output logic              unord
);

  logic        signA;
  logic        signB;
  logic [10:0] expA;
  logic [10:0] expB;
  logic [51:0] fracA;
  logic [51:0] fracB;
  logic        zeroA;
  logic        zeroB;
  logic        nanA;
  logic        nanB;
  logic [62:0] magA;
  logic [62:0] magB;
  logic        magLt;
  logic        magEq;
  logic        bothZero;
  logic        sameSign;

  fpUnpack unpackA (
    .word   (a),
    .half   (half),
    .isDbl  (isDbl),
    .sign   (signA),
    .exp    (expA),
    .frac   (fracA),
    .isZero (zeroA),
    .isInf  (),
    .isNan  (nanA)
  );

  fpUnpack unpackB (
    .word   (b),
    .half   (half),
    .isDbl  (isDbl),
    .sign   (signB),
    .exp    (expB),
    .frac   (fracB),
    .isZero (zeroB),
    .isInf  (),
    .isNan  (nanB)
  );

  // Exponent above fraction gives one unsigned magnitude.
  assign magA     = {expA, fracA};
  assign magB     = {expB, fracB};
  assign magLt    = magA < magB;
  assign magEq    = magA == magB;
  assign bothZero = zeroA & zeroB; // +0 and -0 compare equal.
  assign sameSign = signA == signB;

  assign unord = nanA | nanB;

  // Two negatives reverse the magnitude order.
  assign lt = ~unord & ~bothZero &
              ((signA & ~signB) |
               (~signA & ~signB & magLt) |
               (signA & signB & ~magLt & ~magEq));

  assign eq = ~unord & (bothZero | (sameSign & magEq));

endmodule

`default_nettype wire

// ==== rtl/fpCompare.sv ====
// Result registers load only on start; paired mode always compares singles and ignores isDbl.
`default_nettype none

`include "fcmp_defs.svh"

module fpCompare (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  fcmp_pkg::fpWord_u operandA,
  input  fcmp_pkg::fpWord_u operandB,
  input  logic              isDbl,
  input  logic              paired,
  input  logic              search,
  input  logic              afm,
  input  logic [1:0]        cmod,
  output logic [5:0]        flags,
  output logic [1:0]        cond,
  output logic              done
);

  logic        loLt;
  logic        loEq;
  logic        loUnord;
  logic        hiLt;
  logic        hiEq;
  logic        hiUnord;
  logic        loGe;
  logic        loZ;
  logic        hiGe;
  logic        hiZ;
  logic        condLo;
  logic        condHi;
  logic [15:0] signBits;
  logic [3:0]  srchIndex;
  logic        srchFound;
  logic [5:0]  cmpFlags;
  logic [5:0]  nextFlags;
  logic [1:0]  nextCond;

  function automatic logic condSel(input logic ge, input logic z, input logic [1:0] code);
    logic res;
    case (code)
      `FCMP_COND_GE: res = ge;
      `FCMP_COND_LT: res = ~ge;
      `FCMP_COND_EQ: res = z;
      default:       res = ~z;
    endcase
    return res;
  endfunction

  fpCmpLane laneLo (
    .a     (operandA),
    .b     (operandB),
    .half  (1'b0),
    .isDbl (isDbl & ~paired),
    .lt    (loLt),
    .eq    (loEq),
    .unord (loUnord)
  );

  fpCmpLane laneHi (
    .a     (operandA),
    .b     (operandB),
    .half  (1'b1),
    .isDbl (1'b0),
    .lt    (hiLt),
    .eq    (hiEq),
    .unord (hiUnord)
  );

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      signBits[i]     = operandA.lanes[i][7];
      signBits[i + 8] = operandB.lanes[i][7];
    end
  end

  firstBitFind finder (
    .bits  (signBits),
    .index (srchIndex),
    .found (srchFound)
  );

  assign loGe = ~loUnord & ~loLt;
  assign hiGe = ~hiUnord & ~hiLt;
  assign loZ  = loEq & ~afm;
  assign hiZ  = hiEq & ~afm;

  always_comb begin
    cmpFlags                   = 6'b0; // Bit 3 stays clear in compare mode.
    cmpFlags[`FCMP_F_GE]       = loGe;
    cmpFlags[`FCMP_F_UNORD_HI] = loUnord;
    cmpFlags[`FCMP_F_S]        = loLt & ~afm;
    cmpFlags[`FCMP_F_Z]        = loZ;
    cmpFlags[`FCMP_F_UNORD_LO] = loUnord;
  end

  assign nextFlags = search ? {srchFound, srchIndex, srchIndex[1] ^ srchIndex[0]} : cmpFlags;

  assign condLo   = condSel(loGe, loZ, cmod);
  assign condHi   = condSel(hiGe, hiZ, cmod);
  assign nextCond = paired ? {condHi, condLo} : {2{condLo}};

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= 6'b0;
      cond  <= 2'b0;
      done  <= 1'b0;
    end else if (start) begin
      flags <= nextFlags;
      cond  <= nextCond;
      done  <= 1'b1; // Held until the next start reloads the result.
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fpUnpack.sv ====
// Single exponents are remapped, not rebiased, so only relative order is meaningful across formats.
`default_nettype none

module fpUnpack (
  input  fcmp_pkg::fpWord_u word,
  input  logic              half,
  input  logic              isDbl,
  output logic              sign,
  output logic [10:0]       exp,
  output logic [51:0]       frac,
  output logic              isZero,
  output logic              isInf,
  output logic              isNan
);

  logic [31:0] sgl;
  logic        expMax;
  logic        expMin;
  logic        fracNz;

  assign sgl = half ? word.lanes[7:4] : word.lanes[3:0];

  always_comb begin
    if (isDbl) begin
      sign   = word.dbl.sign;
      exp    = word.dbl.exp;
      frac   = word.dbl.frac;
      expMax = &word.dbl.exp;
      expMin = ~|word.dbl.exp;
      fracNz = |word.dbl.frac;
    end else begin
      sign   = sgl[31];
      // Stretching the top bit keeps the exponent order of the single intact.
      exp    = {sgl[30], {3{~sgl[30]}}, sgl[29:23]};
      frac   = {sgl[22:0], 29'b0}; // Left aligned against the double fraction.
      expMax = &sgl[30:23];
      expMin = ~|sgl[30:23];
      fracNz = |sgl[22:0];
    end
  end

  // Denormals keep their fraction and fall below every normal by magnitude.
  assign isZero = expMin & ~fracNz;
  assign isInf  = expMax & ~fracNz;
  assign isNan  = expMax & fracNz;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in its output.
cd "$(dirname "$0")" \
  && verilator --binary --assert -j 0 --top-module fcmp_tb -f verilog.f -o fcmpSim \
  && ./obj_dir/fcmpSim | tee /dev/stderr | grep -qx "Simulation PASSED" \
  && echo "run_sim: test passed" \
  || { echo "run_sim: test failed" >&2; exit 1; }

// ==== verilog.f ====
+incdir+include
rtl/fcmp_pkg.sv
rtl/fpUnpack.sv
rtl/fpCmpLane.sv
rtl/firstBitFind.sv
rtl/fpCompare.sv
rtl/fcmpApb.sv
bench/tbClock.sv
bench/fcmp_assert.sv
bench/fcmp_tb.sv
